/* include/lut_eval_consts.svh */
`ifndef LUT_EVAL_CONSTS_SVH
`define LUT_EVAL_CONSTS_SVH

// Truth table geometry, one table per 7-input function
`define LUT_ADDR_W  7
`define LUT_TABLE_W 128

// Table store
`define LUT_DEPTH   8
`define LUT_IDX_W   3

// Peer evaluation lanes sharing the table store
`define LUT_LANES   2

`endif

/* lut_eval_top.f */
+incdir+include
src/lut_eval_pkg.sv
src/lut_table_ram.sv
src/lut_lane_port.sv
src/lut_rr_arbiter.sv
src/lut_mux_tree.sv
src/lut_mux_bank.sv
src/lut_eval_top.sv
testbench/lut_eval_asserts.sv
testbench/lut_eval_checker.sv
testbench/lut_eval_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LUT evaluator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f lut_eval_top.f --top-module lut_eval_tb -o sim_lut_eval

status=0
./obj_dir/sim_lut_eval +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* src/lut_eval_pkg.sv */
`include "lut_eval_consts.svh"

package lut_eval_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane request, one table lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                    lane;       // Lane that issued the request
        logic [`LUT_IDX_W-1:0]   table_idx;  // Which stored table to use
        logic [`LUT_ADDR_W-1:0]  addr;       // Input pattern of the function
    } lut_req_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Configuration write of one truth table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                    wr;         // Write strobe
        logic [`LUT_IDX_W-1:0]   idx;
        logic [`LUT_TABLE_W-1:0] data;       // Bit n is the output for pattern n
    } lut_cfg_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Evaluation result, a single cycle pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                    valid;
        logic                    lane;       // Lane the bit belongs to
        logic                    value;
    } lut_result_t;

endpackage

/* src/lut_eval_top.sv */
`timescale 1ns/1ps
`include "lut_eval_consts.svh"

module lut_eval_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  lut_eval_pkg::lut_cfg_t     cfg,
    input  logic [`LUT_LANES-1:0]      eval,
    input  logic [`LUT_IDX_W-1:0]      table_idx0,
    input  logic [`LUT_IDX_W-1:0]      table_idx1,
    input  logic [`LUT_ADDR_W-1:0]     addr0,
    input  logic [`LUT_ADDR_W-1:0]     addr1,
    output logic [`LUT_LANES-1:0]      busy,
    output lut_eval_pkg::lut_result_t  result
);

    import lut_eval_pkg::*;

    logic [`LUT_IDX_W-1:0]   lane_idx  [`LUT_LANES];
    logic [`LUT_ADDR_W-1:0]  lane_addr [`LUT_LANES];
    lut_req_t                port_req  [`LUT_LANES];
    lut_req_t                lane_req  [`LUT_LANES];
    logic [`LUT_LANES-1:0]   pending;
    logic [`LUT_LANES-1:0]   grant;
    logic                    gnt_valid;
    lut_req_t                gnt_req;
    logic                    rd_valid;
    logic [`LUT_TABLE_W-1:0] rd_word;
    lut_req_t                rd_req_q;

    assign lane_idx[0]  = table_idx0;
    assign lane_idx[1]  = table_idx1;
    assign lane_addr[0] = addr0;
    assign lane_addr[1] = addr1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane request slots
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    genvar g;
    generate
        for (g = 0; g < `LUT_LANES; g++)
        begin : gen_lane
            lut_lane_port i_port (
                .clk       (clk),
                .arst_n    (arst_n),
                .eval      (eval[g]),
                .table_idx (lane_idx[g]),
                .addr      (lane_addr[g]),
                .grant     (grant[g]),
                .pending   (pending[g]),
                .busy      (busy[g]),
                .req       (port_req[g])
            );

            // Lane tag comes from the slot position
            assign lane_req[g] = '{lane:      1'(g),
                                   table_idx: port_req[g].table_idx,
                                   addr:      port_req[g].addr};
        end
    endgenerate

    lut_rr_arbiter i_arb (
        .clk       (clk),
        .arst_n    (arst_n),
        .pending   (pending),
        .req0      (lane_req[0]),
        .req1      (lane_req[1]),
        .grant     (grant),
        .gnt_valid (gnt_valid),
        .gnt_req   (gnt_req)
    );

    lut_table_ram i_ram (
        .clk      (clk),
        .arst_n   (arst_n),
        .cfg      (cfg),
        .rd_en    (gnt_valid),
        .rd_req   (gnt_req),
        .rd_valid (rd_valid),
        .rd_word  (rd_word),
        .rd_req_q (rd_req_q)
    );

    lut_mux_bank i_bank (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (rd_valid),
        .in_word  (rd_word),
        .in_req   (rd_req_q),
        .result   (result)
    );

endmodule

/* src/lut_lane_port.sv */
`timescale 1ns/1ps
`include "lut_eval_consts.svh"

module lut_lane_port (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     eval,
    input  logic [`LUT_IDX_W-1:0]    table_idx,
    input  logic [`LUT_ADDR_W-1:0]   addr,
    input  logic                     grant,
    output logic                     pending,
    output logic                     busy,
    output lut_eval_pkg::lut_req_t   req
);

    logic [`LUT_IDX_W-1:0]  idx_q;
    logic [`LUT_ADDR_W-1:0] addr_q;

    // One request slot, freed on the edge that ends its grant cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pending <= 1'b0;
        end
        else if (grant)
        begin
            pending <= 1'b0;
        end
        else if (eval && !pending)
        begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (eval && !pending)
        begin
            idx_q  <= table_idx;
            addr_q <= addr;
        end
    end

    assign busy          = pending;  // A strobe while busy is dropped
    assign req.lane      = 1'b0;     // Stamped with the lane number in the top level
    assign req.table_idx = idx_q;
    assign req.addr      = addr_q;

endmodule

/* src/lut_mux_bank.sv */
`timescale 1ns/1ps
`include "lut_eval_consts.svh"

module lut_mux_bank (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    input  logic [`LUT_TABLE_W-1:0]    in_word,
    input  lut_eval_pkg::lut_req_t     in_req,
    output lut_eval_pkg::lut_result_t  result
);

    logic [`LUT_LANES-1:0] tree_value;
    logic                  valid_q;
    logic                  tag_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One tree per lane, so back to back results of both lanes do not collide
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    genvar g;
    generate
        for (g = 0; g < `LUT_LANES; g++)
        begin : gen_tree
            lut_mux_tree i_tree (
                .clk        (clk),
                .table_word (in_word),
                .addr       (in_req.addr),
                .load       (in_valid && (in_req.lane == 1'(g))),
                .value      (tree_value[g])
            );
        end
    endgenerate

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            tag_q <= in_req.lane;
        end
    end

    assign result.valid = valid_q;  // Pulse, no back-pressure
    assign result.lane  = tag_q;
    assign result.value = tree_value[tag_q];

endmodule

/* src/lut_mux_tree.sv */
`timescale 1ns/1ps
`include "lut_eval_consts.svh"

module lut_mux_tree (
    input  logic                     clk,
    input  logic [`LUT_TABLE_W-1:0]  table_word,
    input  logic [`LUT_ADDR_W-1:0]   addr,
    input  logic                     load,
    output logic                     value
);

    // All tree nodes in one vector, level 0 (the leaves) at the bottom,
    // each level above it half as wide, the root in the top bit
    localparam int NODES = 2 * `LUT_TABLE_W - 1;

    logic [`LUT_TABLE_W-1:0] leaf_q;
    logic [`LUT_ADDR_W-1:0]  sel_q;
    logic [NODES-1:0]        node;

    // Select is held with the leaves so a later load cannot skew them
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            leaf_q <= table_word;
            sel_q  <= addr;
        end
    end

    assign node[`LUT_TABLE_W-1:0] = leaf_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reduction, select bit l picks between neighbours at level l
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    genvar l;
    genvar k;
    generate
        for (l = 0; l < `LUT_ADDR_W; l++)
        begin : gen_level
            localparam int OFF_IN  = (2 * `LUT_TABLE_W) - ((2 * `LUT_TABLE_W) >> l);
            localparam int OFF_OUT = (2 * `LUT_TABLE_W) - ((2 * `LUT_TABLE_W) >> (l + 1));
            localparam int N_OUT   = `LUT_TABLE_W >> (l + 1);

            for (k = 0; k < N_OUT; k++)
            begin : gen_mux
                assign node[OFF_OUT + k] = sel_q[l] ? node[OFF_IN + 2 * k + 1]
                                                    : node[OFF_IN + 2 * k];
            end
        end
    endgenerate

    assign value = node[NODES-1];  // Root of the tree

endmodule

/* src/lut_rr_arbiter.sv */
`timescale 1ns/1ps
`include "lut_eval_consts.svh"

module lut_rr_arbiter (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [`LUT_LANES-1:0]    pending,
    input  lut_eval_pkg::lut_req_t   req0,
    input  lut_eval_pkg::lut_req_t   req1,
    output logic [`LUT_LANES-1:0]    grant,
    output logic                     gnt_valid,
    output lut_eval_pkg::lut_req_t   gnt_req
);

    logic prio;  // Lane that wins when both are pending

    always_comb
    begin
        grant = '0;
        if (pending[0] && (!pending[1] || !prio))
        begin
            grant[0] = 1'b1;
        end
        else if (pending[1])
        begin
            grant[1] = 1'b1;
        end
    end

    assign gnt_valid = |grant;
    assign gnt_req   = grant[1] ? req1 : req0;

    // The lane just served drops to the back
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            prio <= 1'b0;
        end
        else if (gnt_valid)
        begin
            prio <= grant[0];
        end
    end

endmodule

/* src/lut_table_ram.sv */
`timescale 1ns/1ps
`include "lut_eval_consts.svh"

module lut_table_ram (
    input  logic                     clk,
    input  logic                     arst_n,
    input  lut_eval_pkg::lut_cfg_t   cfg,
    input  logic                     rd_en,
    input  lut_eval_pkg::lut_req_t   rd_req,
    output logic                     rd_valid,
    output logic [`LUT_TABLE_W-1:0]  rd_word,
    output lut_eval_pkg::lut_req_t   rd_req_q
);

    logic [`LUT_TABLE_W-1:0] mem [`LUT_DEPTH];

    always_ff @(posedge clk)
    begin
        if (cfg.wr)
        begin
            mem[cfg.idx] <= cfg.data;
        end
    end

    // A write and a read of the same entry in one cycle returns the old word
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_word  <= mem[rd_req.table_idx];
            rd_req_q <= rd_req;  // Tag and pattern travel with the word
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_en;
        end
    end

endmodule

/* testbench/lut_eval_asserts.sv */
`timescale 1ns/1ps
`include "lut_eval_consts.svh"

module lut_eval_asserts (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`LUT_LANES-1:0]  pending,
    input  logic [`LUT_LANES-1:0]  grant
);

    int fail_count = 0;  // Assertion failures seen so far

    a_grant_onehot : assert property (@(posedge clk) disable iff (!arst_n) $onehot0(grant))
    else
    begin
        $error("Both lanes granted in one cycle");
        fail_count++;
    end

    a_grant_pending : assert property (@(posedge clk) disable iff (!arst_n)
                                       (grant & ~pending) == '0)
    else
    begin
        $error("Grant given to a lane with no pending request");
        fail_count++;
    end

    // A lane passed over once must win on the next cycle
    a_lane0_served : assert property (@(posedge clk) disable iff (!arst_n)
                                      pending[0] && !grant[0] |=> grant[0])
    else
    begin
        $error("Lane 0 left waiting for more than one cycle");
        fail_count++;
    end

    a_lane1_served : assert property (@(posedge clk) disable iff (!arst_n)
                                      pending[1] && !grant[1] |=> grant[1])
    else
    begin
        $error("Lane 1 left waiting for more than one cycle");
        fail_count++;
    end

endmodule

bind lut_rr_arbiter lut_eval_asserts i_asserts (
    .clk     (clk),
    .arst_n  (arst_n),
    .pending (pending),
    .grant   (grant)
);

/* testbench/lut_eval_checker.sv */
`timescale 1ns/1ps
`include "lut_eval_consts.svh"

module lut_eval_checker (
    input  logic                       clk,
    input  logic                       arst_n,
    input  lut_eval_pkg::lut_cfg_t     cfg,
    input  logic [`LUT_LANES-1:0]      eval,
    input  logic [`LUT_IDX_W-1:0]      table_idx0,
    input  logic [`LUT_IDX_W-1:0]      table_idx1,
    input  logic [`LUT_ADDR_W-1:0]     addr0,
    input  logic [`LUT_ADDR_W-1:0]     addr1,
    input  logic [`LUT_LANES-1:0]      busy,
    input  lut_eval_pkg::lut_result_t  result,
    input  logic [2:0]                 test_id,
    output int                         err_count,
    output int                         outstanding
);

    logic [`LUT_TABLE_W-1:0] shadow [`LUT_DEPTH];
    logic [3:0]              exp_q0 [$];  // Entries are {test id, expected bit}
    logic [3:0]              exp_q1 [$];
    logic [`LUT_LANES-1:0]   accepted_q = '0;
    logic [`LUT_LANES-1:0]   busy_q = '0;
    logic                    reset_held = 1'b0;
    int                      released [`LUT_LANES];
    int                      completed [`LUT_LANES];
    int                      errors = 0;
    int                      pending_cnt = 0;

    assign err_count   = errors;
    assign outstanding = pending_cnt;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "single_lane";
            3'd2:    return "dual_lane";
            3'd3:    return "table_rewrite";
            3'd4:    return "walking_one";
            3'd5:    return "mid_run_reset";
            default: return "reset";
        endcase
    endfunction

    task automatic check_result(input int lane, input logic value);
        logic [3:0] entry;
        if ((lane == 0 && exp_q0.size() == 0) || (lane == 1 && exp_q1.size() == 0))
        begin
            $display("Lane %0d returned a result with no request outstanding", lane);
            errors++;
        end
        else
        begin
            if (completed[lane] >= released[lane])
            begin
                $display("Lane %0d result appeared before its busy level fell", lane);
                errors++;
            end
            entry = (lane == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
            completed[lane]++;
            if (entry[0] !== value)
            begin
                $display("ERR %s lane %0d expected %0b actual %0b",
                         test_name(entry[3:1]), lane, entry[0], value);
                errors++;
            end
        end
    endtask

    task automatic watch_lane(input int lane, input logic ev, input logic bsy,
                              input logic [`LUT_IDX_W-1:0] idx,
                              input logic [`LUT_ADDR_W-1:0] pat);
        logic exp_bit;
        if (accepted_q[lane] && !bsy)
        begin
            $display("Lane %0d busy did not rise after an accepted strobe", lane);
            errors++;
        end
        if (busy_q[lane] && !bsy)
        begin
            released[lane]++;
        end
        accepted_q[lane] = ev && !bsy;
        busy_q[lane]     = bsy;
        if (ev && !bsy)
        begin
            exp_bit = shadow[idx][pat];  // Bit n of the table is the output for pattern n
            if (lane == 0)
            begin
                exp_q0.push_back({test_id, exp_bit});
            end
            else
            begin
                exp_q1.push_back({test_id, exp_bit});
            end
        end
    endtask

    always @(posedge clk)
    begin
        if (!arst_n)
        begin
            if (reset_held && (busy != '0 || result.valid))
            begin
                $display("Busy or result valid is high while reset is held");
                errors++;
            end
            reset_held = 1'b1;
            exp_q0.delete();  // Requests in flight are lost, the tables are kept
            exp_q1.delete();
            accepted_q = '0;
            busy_q     = '0;
            for (int g = 0; g < `LUT_LANES; g++)
            begin
                released[g]  = 0;
                completed[g] = 0;
            end
        end
        else
        begin
            reset_held = 1'b0;
            if (result.valid)
            begin
                check_result(int'(result.lane), result.value);
            end
            if (cfg.wr)
            begin
                shadow[cfg.idx] = cfg.data;
            end
            watch_lane(0, eval[0], busy[0], table_idx0, addr0);
            watch_lane(1, eval[1], busy[1], table_idx1, addr1);
        end
        pending_cnt = exp_q0.size() + exp_q1.size();
    end

endmodule

/* testbench/lut_eval_tb.sv */
`timescale 1ns/1ps
`include "lut_eval_consts.svh"

module lut_eval_tb;

    import lut_eval_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_SINGLE   = 80;
    localparam int N_DUAL     = 60;
    localparam int N_REWRITE  = 6;
    localparam int N_WALK     = 9;
    localparam int N_RESUME   = 40;
    // Table loads, strobes and resets, each one operation
    localparam int TOTAL_OPS  = 2 * `LUT_DEPTH + N_SINGLE + 2 * N_DUAL + N_REWRITE * 9
                              + N_WALK * 9 + 12 + N_RESUME + 2;
    localparam int WATCHDOG_NS = TOTAL_OPS * 10 * CLK_PERIOD;

    logic                     clk = 1'b0;
    logic                     arst_n;
    lut_cfg_t                 cfg;
    logic [`LUT_LANES-1:0]    eval;
    logic [`LUT_IDX_W-1:0]    table_idx0;
    logic [`LUT_IDX_W-1:0]    table_idx1;
    logic [`LUT_ADDR_W-1:0]   addr0;
    logic [`LUT_ADDR_W-1:0]   addr1;
    logic [`LUT_LANES-1:0]    busy;
    lut_result_t              result;
    logic [2:0]               test_id;
    int                       err_count;
    int                       outstanding;
    int                       walk_pos [N_WALK] = '{0, 1, 2, 4, 8, 16, 32, 64, 127};

    always #(CLK_PERIOD / 2) clk = ~clk;

    lut_eval_top i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg        (cfg),
        .eval       (eval),
        .table_idx0 (table_idx0),
        .table_idx1 (table_idx1),
        .addr0      (addr0),
        .addr1      (addr1),
        .busy       (busy),
        .result     (result)
    );

    lut_eval_checker i_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg         (cfg),
        .eval        (eval),
        .table_idx0  (table_idx0),
        .table_idx1  (table_idx1),
        .addr0       (addr0),
        .addr1       (addr1),
        .busy        (busy),
        .result      (result),
        .test_id     (test_id),
        .err_count   (err_count),
        .outstanding (outstanding)
    );

    function automatic logic [`LUT_TABLE_W-1:0] random_word();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic start_test(input logic [2:0] id);
        @(posedge clk);
        test_id <= id;
    endtask

    // Status is read on the falling edge, where nothing changes
    task automatic wait_idle();
        do
            @(negedge clk);
        while (outstanding != 0 || busy != '0);
    endtask

    task automatic write_table(input logic [`LUT_IDX_W-1:0] idx,
                               input logic [`LUT_TABLE_W-1:0] data);
        @(posedge clk);
        cfg <= '{wr: 1'b1, idx: idx, data: data};
        @(posedge clk);
        cfg <= '0;
    endtask

    task automatic load_random_tables();
        wait_idle();
        for (int i = 0; i < `LUT_DEPTH; i++)
        begin
            write_table(3'(i), random_word());
        end
    endtask

    task automatic issue(input int lane, input logic [`LUT_IDX_W-1:0] idx,
                         input logic [`LUT_ADDR_W-1:0] pat);
        do
            @(negedge clk);
        while (busy[lane]);
        @(posedge clk);
        eval[lane] <= 1'b1;
        if (lane == 0)
        begin
            table_idx0 <= idx;
            addr0      <= pat;
        end
        else
        begin
            table_idx1 <= idx;
            addr1      <= pat;
        end
        @(posedge clk);
        eval[lane] <= 1'b0;
    endtask

    task automatic issue_pair(input logic [`LUT_IDX_W-1:0] idx0, input logic [`LUT_ADDR_W-1:0] pat0,
                              input logic [`LUT_IDX_W-1:0] idx1, input logic [`LUT_ADDR_W-1:0] pat1);
        do
            @(negedge clk);
        while (busy != '0);
        @(posedge clk);
        eval       <= 2'b11;
        table_idx0 <= idx0;
        addr0      <= pat0;
        table_idx1 <= idx1;
        addr1      <= pat1;
        @(posedge clk);
        eval <= 2'b00;
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        eval   <= '0;
        arst_n <= 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h470f0a17));
        arst_n     = 1'b0;
        cfg        = '0;
        eval       = '0;
        table_idx0 = '0;
        table_idx1 = '0;
        addr0      = '0;
        addr1      = '0;
        test_id    = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        start_test(3'd1);
        load_random_tables();
        for (int i = 0; i < N_SINGLE; i++)
        begin
            issue((i < N_SINGLE / 2) ? 0 : 1, 3'($urandom()), 7'($urandom()));
        end

        start_test(3'd2);
        load_random_tables();
        for (int i = 0; i < N_DUAL; i++)
        begin
            issue_pair(3'($urandom()), 7'($urandom()), 3'($urandom()), 7'($urandom()));
        end

        start_test(3'd3);
        for (int r = 0; r < N_REWRITE; r++)
        begin
            wait_idle();
            write_table(3'(r), random_word());
            for (int i = 0; i < 8; i++)
            begin
                issue(i % 2, 3'(r), 7'($urandom()));
            end
        end

        // One hot tables, then the hot pattern and its neighbour at every select level
        start_test(3'd4);
        for (int p = 0; p < N_WALK; p++)
        begin
            wait_idle();
            write_table(3'(p), 128'(1) << walk_pos[p]);
            issue(0, 3'(p), 7'(walk_pos[p]));
            for (int l = 0; l < `LUT_ADDR_W; l++)
            begin
                issue(l % 2, 3'(p), 7'(walk_pos[p] ^ (1 << l)));
            end
        end

        start_test(3'd5);
        for (int i = 0; i < 12; i++)
        begin
            issue(i % 2, 3'($urandom()), 7'($urandom()));
        end
        pulse_reset();
        for (int i = 0; i < N_RESUME; i++)
        begin
            issue(i % 2, 3'($urandom()), 7'($urandom()));
        end
        wait_idle();

        $display("Errors: %0d from the checker, %0d from assertions",
                 err_count, i_dut.i_arb.i_asserts.fail_count);
        if (err_count == 0 && i_dut.i_arb.i_asserts.fail_count == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
